/* matmul.f */
+incdir+.
mm_cfg_pkg.sv
mm_ctrl_pkg.sv
mem_port_if.sv
row_ram.sv
mem_arbiter.sv
mac_lane_array.sv
matmul_engine.sv
matmul_top.sv
tb_matmul_top.sv

/* run.sh */
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f matmul.f \
  --top-module tb_matmul_top \
  -o tb_matmul_top

./obj_dir/tb_matmul_top

/* tb_matmul_model.svh */
`ifndef TB_MATMUL_MODEL_SVH
`define TB_MATMUL_MODEL_SVH

// C = A x B, every sum wraps at data_width
function automatic void compute_product();
  logic [data_width-1:0] sum;
  for (int i = 0; i < mat_size; i++)
  begin
    for (int j = 0; j < mat_size; j++)
    begin
      sum = '0;
      for (int k = 0; k < mat_size; k++)
      begin
        sum = sum + a_m[i][k] * b_m[k][j];
      end
      c_m[i][j] = sum;
    end
  end
endfunction

// Packs one matrix row, lane j at bits j*data_width
// which: 0 A, 1 B, 2 C, 3 previous C
function automatic logic [row_width-1:0] matrix_row(input int which, input int i);
  logic [row_width-1:0] row;
  row = '0;
  for (int j = 0; j < mat_size; j++)
  begin
    case (which)
      0: row[j*data_width +: data_width] = a_m[i][j];
      1: row[j*data_width +: data_width] = b_m[i][j];
      2: row[j*data_width +: data_width] = c_m[i][j];
      default: row[j*data_width +: data_width] = c_old[i][j];
    endcase
  end
  return row;
endfunction

task automatic check_value(input string name, input logic [row_width-1:0] expected,
                           input logic [row_width-1:0] actual);
  if (expected !== actual)
  begin
    $display("FAIL %s expected %h actual %h", name, expected, actual);
    $display("STATUS: FAIL");
    $fatal(1, "value mismatch in %s", name);
  end
  else
  begin
    check_count++;
  end
endtask

`endif

/* tb_matmul_top.sv */
`timescale 1ns/1ps

module tb_matmul_top;

  localparam int mat_size     = mm_cfg_pkg::DEFAULT_MAT_SIZE;
  localparam int data_width   = mm_cfg_pkg::DEFAULT_DATA_WIDTH;
  localparam int row_width    = mat_size * data_width;
  localparam int row_bits     = $clog2(mat_size);
  localparam int clk_period   = 4;
  localparam int reset_cycles = 16;
  localparam int num_tests    = 10;
  localparam int run_cycles   = mat_size * (mat_size + 3) + 1;
  localparam int watchdog_cycles =
    num_tests * (mat_size * (mat_size + 3) + 4 * mat_size + 50) + reset_cycles;

  logic                  clk;
  logic                  arst_n;
  mm_ctrl_pkg::host_op_e host_op;
  logic [row_bits-1:0]   host_row;
  logic [row_width-1:0]  host_wdata;
  logic [row_width-1:0]  host_rdata;
  logic                  start;
  logic                  busy;
  logic                  done;

  integer seed;
  int     check_count;

  logic [data_width-1:0] a_m   [mat_size][mat_size];
  logic [data_width-1:0] b_m   [mat_size][mat_size];
  logic [data_width-1:0] c_m   [mat_size][mat_size];
  logic [data_width-1:0] c_old [mat_size][mat_size];

  `include "tb_matmul_model.svh"

  matmul_top #(
    .mat_size   (mat_size),
    .data_width (data_width)
  ) i_matmul_top (
    .clk        (clk),
    .arst_n     (arst_n),
    .host_op    (host_op),
    .host_row   (host_row),
    .host_wdata (host_wdata),
    .host_rdata (host_rdata),
    .start      (start),
    .busy       (busy),
    .done       (done)
  );

  always #(clk_period / 2) clk = ~clk;

  //////////////////////////////
  // Host side helpers

  // One command cycle that ends 1 ns after the sampling edge
  task automatic host_cmd(input mm_ctrl_pkg::host_op_e op, input int row,
                          input logic [row_width-1:0] wdata);
    host_op    = op;
    host_row   = row_bits'(row);
    host_wdata = wdata;
    @(posedge clk);
    #1;
    host_op = mm_ctrl_pkg::HOST_NOP;
  endtask

  task automatic read_row_check(input string name, input int row,
                                input logic [row_width-1:0] expected);
    host_cmd(mm_ctrl_pkg::HOST_RD_C, row, '0);
    check_value(name, expected, host_rdata);
  endtask

  // Kind 0 is random, 1 identity and 2 zero
  task automatic fill_matrices(input int a_kind, input int b_kind);
    for (int i = 0; i < mat_size; i++)
    begin
      for (int k = 0; k < mat_size; k++)
      begin
        a_m[i][k] = (a_kind == 1) ? data_width'(i == k) : data_width'($random(seed));
        b_m[i][k] = (b_kind == 2) ? '0 : data_width'($random(seed));
      end
    end
  endtask

  //////////////////////////////
  // One full product

  task automatic run_product(input bit host_reads, input bit extra_start,
                             input bit after_done);
    int cycles;
    int rd_row;
    bit rd_pending;
    for (int i = 0; i < mat_size; i++)
    begin
      host_cmd(mm_ctrl_pkg::HOST_WR_A, i, matrix_row(0, i));
    end
    for (int i = 0; i < mat_size; i++)
    begin
      host_cmd(mm_ctrl_pkg::HOST_WR_B, i, matrix_row(1, i));
    end
    if (after_done)
      check_value("done_held", 1, done);
    c_old = c_m;
    compute_product();
    start = 1'b1;
    @(posedge clk);
    #1;
    start = 1'b0;
    check_value("busy_rise", 1, busy);
    check_value("done_clear", 0, done);
    cycles     = 0;
    rd_row     = 0;
    rd_pending = 1'b0;
    while (!done)
    begin
      if (host_reads && ($random(seed) & 3) == 0)
      begin
        rd_row     = $random(seed) & (mat_size - 1);
        host_op    = mm_ctrl_pkg::HOST_RD_C;
        host_row   = row_bits'(rd_row);
        rd_pending = 1'b1;
      end
      // Mid-run start that the engine ignores
      if (extra_start && cycles == 2 * mat_size)
        start = 1'b1;
      @(posedge clk);
      #1;
      cycles++;
      host_op = mm_ctrl_pkg::HOST_NOP;
      start   = 1'b0;
      if (rd_pending)
      begin
        // Row is either not yet rewritten or already the new one
        if (host_rdata !== matrix_row(2, rd_row))
          check_value("busy_read", matrix_row(3, rd_row), host_rdata);
        rd_pending = 1'b0;
      end
      if (!done)
        check_value("busy_held", 1, busy);
    end
    check_value("busy_fall", 0, busy);
    if (!host_reads)
      check_value("done_latency", run_cycles, cycles);
  endtask

  initial
  begin
    #(watchdog_cycles * clk_period);
    $display("Timeout: run did not finish within %0d cycles", watchdog_cycles);
    $display("STATUS: FAIL");
    $fatal(1, "watchdog expired");
  end

  initial
  begin
    seed        = 32'hc83ad1b2;
    check_count = 0;
    clk         = 1'b0;
    arst_n      = 1'b0;
    host_op     = mm_ctrl_pkg::HOST_NOP;
    host_row    = '0;
    host_wdata  = '0;
    start       = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    #1;
    arst_n = 1'b1;
    check_value("reset_busy", 0, busy);
    check_value("reset_done", 0, done);
    check_value("reset_rdata", 0, host_rdata);

    for (int p = 0; p < 8; p++)
    begin
      fill_matrices(0, 0);
      run_product(p % 2 == 1, p == 2, p > 0);
      for (int i = 0; i < mat_size; i++)
      begin
        read_row_check("random_c_row", i, matrix_row(2, i));
      end
    end

    fill_matrices(1, 0);
    run_product(1'b0, 1'b0, 1'b1);
    for (int i = 0; i < mat_size; i++)
    begin
      read_row_check("identity_c_row", i, matrix_row(1, i));
    end

    fill_matrices(0, 2);
    run_product(1'b0, 1'b0, 1'b1);
    for (int i = 0; i < mat_size; i++)
    begin
      read_row_check("zero_c_row", i, '0);
    end

    if (check_count > 0)
    begin
      $display("STATUS: PASS");
      $finish;
    end
    else
    begin
      $display("No checks were run");
      $display("STATUS: FAIL");
      $fatal(1, "empty run");
    end
  end

endmodule

/* matmul_top.sv */
`timescale 1ns/1ps

module matmul_top #(
  parameter int mat_size   = mm_cfg_pkg::DEFAULT_MAT_SIZE,
  parameter int data_width = mm_cfg_pkg::DEFAULT_DATA_WIDTH,
  localparam int row_width = mat_size * data_width,
  localparam int row_bits  = $clog2(mat_size)
) (
  input  logic                  clk,
  input  logic                  arst_n,
  input  mm_ctrl_pkg::host_op_e host_op,
  input  logic [row_bits-1:0]   host_row,
  input  logic [row_width-1:0]  host_wdata,
  output logic [row_width-1:0]  host_rdata,
  input  logic                  start,
  output logic                  busy,
  output logic                  done
);

  localparam int addr_bits = mm_cfg_pkg::REGION_BITS + row_bits;

  logic [addr_bits-1:0] ram_addr;
  logic [row_width-1:0] ram_wdata;
  logic                 ram_we;
  logic [row_width-1:0] ram_rdata;
  logic                 host_rd_q;
  logic [row_width-1:0] rdata_hold;

  mem_port_if #(.mat_size(mat_size), .data_width(data_width)) host_port ();
  mem_port_if #(.mat_size(mat_size), .data_width(data_width)) eng_port ();

  //////////////////////////////
  // Host command decode

  always_comb
  begin
    host_port.req    = (host_op != mm_ctrl_pkg::HOST_NOP);
    host_port.we     = (host_op == mm_ctrl_pkg::HOST_WR_A) ||
                       (host_op == mm_ctrl_pkg::HOST_WR_B);
    host_port.row    = host_row;
    host_port.wdata  = host_wdata;
    case (host_op)
      mm_ctrl_pkg::HOST_WR_A: host_port.region = mm_cfg_pkg::REGION_A;
      mm_ctrl_pkg::HOST_WR_B: host_port.region = mm_cfg_pkg::REGION_B;
      default:                host_port.region = mm_cfg_pkg::REGION_C;
    endcase
  end

  // Read data shows one cycle after the command, then holds
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      host_rd_q  <= 1'b0;
      rdata_hold <= '0;
    end
    else
    begin
      host_rd_q <= (host_op == mm_ctrl_pkg::HOST_RD_C);
      if (host_rd_q)
        rdata_hold <= host_port.rdata;
    end
  end

  assign host_rdata = host_rd_q ? host_port.rdata : rdata_hold;

  row_ram #(.mat_size(mat_size), .data_width(data_width)) i_row_ram (
    .clk   (clk),
    .addr  (ram_addr),
    .wdata (ram_wdata),
    .we    (ram_we),
    .rdata (ram_rdata)
  );

  mem_arbiter #(.mat_size(mat_size), .data_width(data_width)) i_mem_arbiter (
    .clk       (clk),
    .arst_n    (arst_n),
    .host_port (host_port.arbiter),
    .eng_port  (eng_port.arbiter),
    .addr      (ram_addr),
    .wdata     (ram_wdata),
    .we        (ram_we),
    .rdata     (ram_rdata)
  );

  matmul_engine #(.mat_size(mat_size), .data_width(data_width)) i_matmul_engine (
    .clk    (clk),
    .arst_n (arst_n),
    .start  (start),
    .busy   (busy),
    .done   (done),
    .mem    (eng_port.requester)
  );

endmodule

/* matmul_engine.sv */
`timescale 1ns/1ps

module matmul_engine #(
  parameter int mat_size   = mm_cfg_pkg::DEFAULT_MAT_SIZE,
  parameter int data_width = mm_cfg_pkg::DEFAULT_DATA_WIDTH
) (
  input  logic          clk,
  input  logic          arst_n,
  input  logic          start,
  output logic          busy,
  output logic          done,
  mem_port_if.requester mem
);

  localparam int row_width = mat_size * data_width;
  localparam int row_bits  = $clog2(mat_size);
  localparam logic [row_bits-1:0] last_idx = row_bits'(mat_size - 1);

  mm_ctrl_pkg::engine_state_e state;
  logic [row_bits-1:0]   row_cnt;
  logic [row_bits-1:0]   col_cnt;
  logic [row_bits-1:0]   b_k;
  logic                  a_pend;
  logic                  b_pend;
  logic [row_width-1:0]  a_hold;
  logic [data_width-1:0] a_elem;
  logic [row_width-1:0]  c_row;

  //////////////////////////////
  // Row sequencing

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state   <= mm_ctrl_pkg::ST_IDLE;
      row_cnt <= '0;
      col_cnt <= '0;
      done    <= 1'b0;
    end
    else
    begin
      case (state)
        mm_ctrl_pkg::ST_IDLE:
          if (start)
          begin
            state   <= mm_ctrl_pkg::ST_RD_A;
            row_cnt <= '0;
            done    <= 1'b0;
          end
        mm_ctrl_pkg::ST_RD_A:
          if (mem.gnt)
          begin
            state   <= mm_ctrl_pkg::ST_RD_B;
            col_cnt <= '0;
          end
        mm_ctrl_pkg::ST_RD_B:
          if (mem.gnt)
          begin
            if (col_cnt == last_idx)
              state <= mm_ctrl_pkg::ST_ACC;
            else
              col_cnt <= col_cnt + 1'b1;
          end
        // Last B row still in the lanes
        mm_ctrl_pkg::ST_ACC:
          state <= mm_ctrl_pkg::ST_WR_C;
        mm_ctrl_pkg::ST_WR_C:
          if (mem.gnt)
          begin
            if (row_cnt == last_idx)
            begin
              state <= mm_ctrl_pkg::ST_DONE;
            end
            else
            begin
              row_cnt <= row_cnt + 1'b1;
              state   <= mm_ctrl_pkg::ST_RD_A;
            end
          end
        mm_ctrl_pkg::ST_DONE:
        begin
          state <= mm_ctrl_pkg::ST_IDLE;
          done  <= 1'b1;
        end
        default:
          state <= mm_ctrl_pkg::ST_IDLE;
      endcase
    end
  end

  assign busy = (state != mm_ctrl_pkg::ST_IDLE);

  // Reads in flight, data lands one cycle after grant
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      a_pend <= 1'b0;
      b_pend <= 1'b0;
    end
    else
    begin
      a_pend <= (state == mm_ctrl_pkg::ST_RD_A) && mem.gnt;
      b_pend <= (state == mm_ctrl_pkg::ST_RD_B) && mem.gnt;
    end
  end

  always_ff @(posedge clk)
  begin
    if (a_pend)
      a_hold <= mem.rdata;
    if ((state == mm_ctrl_pkg::ST_RD_B) && mem.gnt)
      b_k <= col_cnt;
  end

  assign a_elem = a_hold[b_k*data_width +: data_width];

  always_comb
  begin
    mem.req    = 1'b0;
    mem.we     = 1'b0;
    mem.region = mm_cfg_pkg::REGION_C;
    mem.row    = row_cnt;
    mem.wdata  = c_row;
    case (state)
      mm_ctrl_pkg::ST_RD_A:
      begin
        mem.req    = 1'b1;
        mem.region = mm_cfg_pkg::REGION_A;
      end
      mm_ctrl_pkg::ST_RD_B:
      begin
        mem.req    = 1'b1;
        mem.region = mm_cfg_pkg::REGION_B;
        mem.row    = col_cnt;
      end
      mm_ctrl_pkg::ST_WR_C:
      begin
        mem.req = 1'b1;
        mem.we  = 1'b1;
      end
      default:
      begin
      end
    endcase
  end

  mac_lane_array #(
    .mat_size   (mat_size),
    .data_width (data_width)
  ) i_mac_lane_array (
    .clk    (clk),
    .arst_n (arst_n),
    .clear  (state == mm_ctrl_pkg::ST_RD_A),
    .valid  (b_pend),
    .a_elem (a_elem),
    .b_row  (mem.rdata),
    .c_row  (c_row)
  );

  // A second start mid-run must not end or restart it
  assert property (@(posedge clk) disable iff (!arst_n)
    (start && busy && state != mm_ctrl_pkg::ST_DONE) |=> busy && !done);

endmodule

/* mac_lane_array.sv */
`timescale 1ns/1ps

module mac_lane_array #(
  parameter int mat_size   = mm_cfg_pkg::DEFAULT_MAT_SIZE,
  parameter int data_width = mm_cfg_pkg::DEFAULT_DATA_WIDTH,
  localparam int row_width = mat_size * data_width
) (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  clear,
  input  logic                  valid,
  input  logic [data_width-1:0] a_elem,
  input  logic [row_width-1:0]  b_row,
  output logic [row_width-1:0]  c_row
);

  logic [data_width-1:0] acc [mat_size];

  // One lane per output column, sums wrap at data_width
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      for (int j = 0; j < mat_size; j++)
      begin
        acc[j] <= '0;
      end
    end
    else if (clear)
    begin
      for (int j = 0; j < mat_size; j++)
      begin
        acc[j] <= '0;
      end
    end
    else if (valid)
    begin
      for (int j = 0; j < mat_size; j++)
      begin
        acc[j] <= acc[j] + a_elem * b_row[j*data_width +: data_width];
      end
    end
  end

  always_comb
  begin
    for (int j = 0; j < mat_size; j++)
    begin
      c_row[j*data_width +: data_width] = acc[j];
    end
  end

endmodule

/* mem_arbiter.sv */
`timescale 1ns/1ps

module mem_arbiter #(
  parameter int mat_size   = mm_cfg_pkg::DEFAULT_MAT_SIZE,
  parameter int data_width = mm_cfg_pkg::DEFAULT_DATA_WIDTH,
  localparam int row_width = mat_size * data_width,
  localparam int addr_bits = mm_cfg_pkg::REGION_BITS + $clog2(mat_size)
) (
  input  logic                 clk,
  input  logic                 arst_n,
  mem_port_if.arbiter          host_port,
  mem_port_if.arbiter          eng_port,
  output logic [addr_bits-1:0] addr,
  output logic [row_width-1:0] wdata,
  output logic                 we,
  input  logic [row_width-1:0] rdata
);

  logic rd_host_q;
  logic rd_eng_q;

  // Host always wins over the engine
  assign host_port.gnt = host_port.req;
  assign eng_port.gnt  = eng_port.req && !host_port.req;

  always_comb
  begin
    if (host_port.req)
    begin
      addr  = {host_port.region, host_port.row};
      wdata = host_port.wdata;
      we    = host_port.we;
    end
    else
    begin
      addr  = {eng_port.region, eng_port.row};
      wdata = eng_port.wdata;
      we    = eng_port.req && eng_port.we;
    end
  end

  //////////////////////////////
  // Read data return

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      rd_host_q <= 1'b0;
      rd_eng_q  <= 1'b0;
    end
    else
    begin
      rd_host_q <= host_port.gnt && !host_port.we;
      rd_eng_q  <= eng_port.gnt && !eng_port.we;
    end
  end

  assign host_port.rdata = rd_host_q ? rdata : '0;
  assign eng_port.rdata  = rd_eng_q ? rdata : '0;

  // A stalled engine request waits unchanged for its grant
  assert property (@(posedge clk) disable iff (!arst_n)
    (eng_port.req && !eng_port.gnt) |=>
      (eng_port.req && $stable(eng_port.we) && $stable(eng_port.region) &&
       $stable(eng_port.row)));

  // Engine only ever stores results
  assert property (@(posedge clk) disable iff (!arst_n)
    (eng_port.gnt && eng_port.we) |-> eng_port.region == mm_cfg_pkg::REGION_C);

endmodule

/* row_ram.sv */
`timescale 1ns/1ps

module row_ram #(
  parameter int mat_size   = mm_cfg_pkg::DEFAULT_MAT_SIZE,
  parameter int data_width = mm_cfg_pkg::DEFAULT_DATA_WIDTH,
  localparam int row_width = mat_size * data_width,
  localparam int addr_bits = mm_cfg_pkg::REGION_BITS + $clog2(mat_size)
) (
  input  logic                 clk,
  input  logic [addr_bits-1:0] addr,
  input  logic [row_width-1:0] wdata,
  input  logic                 we,
  output logic [row_width-1:0] rdata
);

  logic [row_width-1:0] mem [4*mat_size];

  // Read returns the old word when writing the same address
  always_ff @(posedge clk)
  begin
    if (we)
    begin
      mem[addr] <= wdata;
    end
    rdata <= mem[addr];
  end

endmodule

/* mem_port_if.sv */
`timescale 1ns/1ps

interface mem_port_if #(
  parameter int mat_size   = mm_cfg_pkg::DEFAULT_MAT_SIZE,
  parameter int data_width = mm_cfg_pkg::DEFAULT_DATA_WIDTH
) ();

  localparam int row_width = mat_size * data_width;
  localparam int row_bits  = $clog2(mat_size);

  logic                    req;
  logic                    we;
  mm_cfg_pkg::mem_region_e region;
  logic [row_bits-1:0]     row;
  logic [row_width-1:0]    wdata;
  logic [row_width-1:0]    rdata;
  logic                    gnt;

  // Request fields held until gnt
  modport requester (
    output req, we, region, row, wdata,
    input  gnt, rdata
  );

  modport arbiter (
    input  req, we, region, row, wdata,
    output gnt, rdata
  );

endinterface

/* mm_ctrl_pkg.sv */
package mm_ctrl_pkg;

  typedef enum logic [1:0] {
    HOST_NOP  = 2'd0,
    HOST_WR_A = 2'd1,
    HOST_WR_B = 2'd2,
    HOST_RD_C = 2'd3
  } host_op_e;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_RD_A,
    ST_RD_B,
    ST_ACC,
    ST_WR_C,
    ST_DONE
  } engine_state_e;

endpackage

/* mm_cfg_pkg.sv */
package mm_cfg_pkg;

  // Matrix dimension and element width
  parameter int DEFAULT_MAT_SIZE   = 4;
  parameter int DEFAULT_DATA_WIDTH = 8;

  // Region code sits above the row index in a memory address
  parameter int REGION_BITS = 2;

  typedef enum logic [REGION_BITS-1:0] {
    REGION_A = 2'd0,
    REGION_B = 2'd1,
    REGION_C = 2'd2
  } mem_region_e;

endpackage
